//--- design/sd_host_pkg.sv
`default_nettype none

package sd_host_pkg;

  localparam int ADDR_W = 17;
  localparam int DATA_W = 32;
  localparam int PKT_W  = 48;
  localparam int RESP_W = 136;

  // top two address bits pick the region
  localparam logic [1:0] REGION_CTRL = 2'd2;
  localparam logic [1:0] REGION_STAT = 2'd3;

  // write offsets, addr[5:2]
  localparam logic [3:0] OFS_ARG     = 4'd2;
  localparam logic [3:0] OFS_CMD     = 4'd3;
  localparam logic [3:0] OFS_SETTING = 4'd4;
  localparam logic [3:0] OFS_START   = 4'd5;
  localparam logic [3:0] OFS_RESETS  = 4'd6;
  localparam logic [3:0] OFS_TIMEOUT = 4'd9;
  localparam logic [3:0] OFS_CLKDIV  = 4'd11;
  localparam logic [3:0] OFS_LED     = 4'd15;

  // read offsets, addr[6:2]
  localparam logic [4:0] RD_RESP0   = 5'd0;
  localparam logic [4:0] RD_RESP1   = 5'd1;
  localparam logic [4:0] RD_RESP2   = 5'd2;
  localparam logic [4:0] RD_RESP3   = 5'd3;
  localparam logic [4:0] RD_WAIT    = 5'd4;
  localparam logic [4:0] RD_STATUS  = 5'd5;
  localparam logic [4:0] RD_PKT_LO  = 5'd6;
  localparam logic [4:0] RD_PKT_HI  = 5'd7;
  localparam logic [4:0] RD_DETECT  = 5'd12;
  localparam logic [4:0] RD_ARG     = 5'd18;
  localparam logic [4:0] RD_CMD     = 5'd19;
  localparam logic [4:0] RD_SETTING = 5'd20;
  localparam logic [4:0] RD_START   = 5'd21;
  localparam logic [4:0] RD_RESETS  = 5'd22;
  localparam logic [4:0] RD_TIMEOUT = 5'd25;
  localparam logic [4:0] RD_CLKDIV  = 5'd27;
  localparam logic [4:0] RD_DIP     = 5'd31;

  localparam logic [DATA_W-1:0] RD_DEFAULT = 32'hDEADBEEF;

  typedef struct packed {
    logic              req;
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } host_bus_t;

  typedef struct packed {
    logic [31:0] arg;
    logic [5:0]  cmd_index;
    logic [2:0]  setting;     // [0] resp, [1] long, [2] crc check
    logic        start;
    logic        cmd_en;
    logic        clk_en;
    logic        card_reset;
    logic [31:0] timeout;
    logic [15:0] clkdiv;
  } sd_cfg_t;

  typedef struct packed {
    logic rise;
    logic fall;
  } sd_tick_t;

  typedef struct packed {
    logic [26:0] pad;
    logic        timed_out;
    logic        index_ok;
    logic        crc_ok;
    logic        busy;
    logic        finish;
  } sd_status_t;

  // R2 layout, CID/CSD body
  typedef struct packed {
    logic         start;
    logic         trans;
    logic [5:0]   rsvd;
    logic [119:0] body;
    logic [6:0]   crc;
    logic         stop;
  } sd_long_resp_t;

  // R1 style, sits in the low 48 bits
  typedef struct packed {
    logic [87:0] pad;
    logic        start;
    logic        trans;
    logic [5:0]  index;
    logic [31:0] card_status;
    logic [6:0]  crc;
    logic        stop;
  } sd_short_resp_t;

  typedef union packed {
    logic [RESP_W-1:0] raw;
    sd_long_resp_t     long_view;
    sd_short_resp_t    short_view;
  } sd_resp_u;

endpackage

`default_nettype wire

//--- design/sd_ctrl_regs.sv
`timescale 1ns/100ps
`default_nettype none

module sd_ctrl_regs (
  input  wire                         msoc_clk,
  input  wire                         rstn,
  input  wire sd_host_pkg::host_bus_t host_i,
  output sd_host_pkg::sd_cfg_t        cfg_o,
  output logic [7:0]                  led_o,
  output logic                        sd_reset_o
);
  import sd_host_pkg::*;

  logic       ctrl_wr;
  logic [3:0] wr_ofs;

  assign ctrl_wr = host_i.req & host_i.we &
                   (host_i.addr[ADDR_W-1:ADDR_W-2] == REGION_CTRL);
  assign wr_ofs  = host_i.addr[5:2];

  assign sd_reset_o = cfg_o.card_reset;  // straight to the card socket

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      cfg_o <= '0;
      led_o <= '0;
    end
    else if (ctrl_wr)
    begin
      case (wr_ofs)
        OFS_ARG:
        begin
          cfg_o.arg <= host_i.wdata;
        end
        OFS_CMD:
        begin
          cfg_o.cmd_index <= host_i.wdata[5:0];
        end
        OFS_SETTING:
        begin
          cfg_o.setting <= host_i.wdata[2:0];
        end
        OFS_START:
        begin
          cfg_o.start <= host_i.wdata[0];  // level, engine looks for 0 to 1
        end
        OFS_RESETS:
        begin
          // bit 1 was the data path reset, now unused
          cfg_o.cmd_en     <= host_i.wdata[0];
          cfg_o.clk_en     <= host_i.wdata[2];
          cfg_o.card_reset <= host_i.wdata[3];
        end
        OFS_TIMEOUT:
        begin
          cfg_o.timeout <= host_i.wdata;
        end
        OFS_CLKDIV:
        begin
          cfg_o.clkdiv <= host_i.wdata[15:0];
        end
        OFS_LED:
        begin
          led_o <= host_i.wdata[7:0];  // activity display
        end
        default:
        begin
          led_o <= led_o;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/sd_clk_div.sv
`timescale 1ns/100ps
`default_nettype none

module sd_clk_div (
  input  wire                   msoc_clk,
  input  wire                   rstn,
  input  wire                   clk_en_i,
  input  wire [15:0]            clkdiv_i,
  output sd_host_pkg::sd_tick_t tick_o,
  output logic                  sd_sclk_o
);

  logic [15:0] half_cnt;
  logic [15:0] half_lim;

  assign half_lim = (clkdiv_i == 16'd0) ? 16'd1 : clkdiv_i;  // 0 runs as 1

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      half_cnt  <= '0;
      sd_sclk_o <= 1'b0;
      tick_o    <= '0;
    end
    else if (!clk_en_i)
    begin
      half_cnt  <= '0;  // park low
      sd_sclk_o <= 1'b0;
      tick_o    <= '0;
    end
    else if (half_cnt >= half_lim)
    begin
      half_cnt    <= '0;
      sd_sclk_o   <= ~sd_sclk_o;
      tick_o.rise <= ~sd_sclk_o;  // same cycle as the new level
      tick_o.fall <= sd_sclk_o;
    end
    else
    begin
      half_cnt <= half_cnt + 16'd1;
      tick_o   <= '0;
    end
  end

endmodule

`default_nettype wire

//--- design/sd_cmd_engine.sv
`timescale 1ns/100ps
`default_nettype none

module sd_cmd_engine (
  input  wire                                  msoc_clk,
  input  wire                                  rstn,
  input  wire sd_host_pkg::sd_cfg_t            cfg_i,
  input  wire sd_host_pkg::sd_tick_t           tick_i,
  input  wire                                  sd_cmd_i,
  output logic                                 sd_cmd_o,
  output logic                                 sd_cmd_oe_o,
  output sd_host_pkg::sd_resp_u                resp_o,
  output logic [sd_host_pkg::PKT_W-1:0]        packet_o,
  output logic [sd_host_pkg::DATA_W-1:0]       wait_cnt_o,
  output sd_host_pkg::sd_status_t              status_o
);
  import sd_host_pkg::*;

  typedef enum logic [2:0] {S_IDLE, S_SEND, S_WAIT, S_CAPT, S_DONE} state_t;

  state_t           state;
  logic             start_q;
  logic             start_rise;
  logic [7:0]       bit_cnt;
  logic [7:0]       resp_len;
  logic             resp_long;
  sd_resp_u         resp_nxt;
  logic [119:0]     crc_data;
  logic [6:0]       crc_rx;
  logic [6:0]       crc_calc;
  logic [6:0]       cmd_crc;
  logic [PKT_W-1:0] cmd_pkt;
  logic             idx_match;

  // x^7 + x^3 + 1, data left aligned, first nbits are used
  function automatic logic [6:0] crc7(input logic [119:0] data, input logic [6:0] nbits);
    logic [6:0] crc;
    logic       fb;
    crc = '0;
    for (int i = 0; i < 120; i++)
    begin
      if (i < nbits)
      begin
        fb  = data[119-i] ^ crc[6];
        crc = {crc[5:0], 1'b0} ^ {3'b000, fb, 2'b00, fb};
      end
    end
    return crc;
  endfunction

  assign start_rise = cfg_i.start & ~start_q;
  assign resp_long  = cfg_i.setting[1];
  assign resp_len   = resp_long ? 8'd136 : 8'd48;

  assign cmd_crc = crc7({2'b01, cfg_i.cmd_index, cfg_i.arg, 80'd0}, 7'd40);
  assign cmd_pkt = {2'b01, cfg_i.cmd_index, cfg_i.arg, cmd_crc, 1'b1};

  // response as it will look after this rise tick
  assign resp_nxt = {resp_o.raw[RESP_W-2:0], sd_cmd_i};

  assign crc_data = resp_long ? resp_nxt.long_view.body :
                    {resp_nxt.short_view.start, resp_nxt.short_view.trans,
                     resp_nxt.short_view.index, resp_nxt.short_view.card_status, 80'd0};
  assign crc_rx    = resp_long ? resp_nxt.long_view.crc : resp_nxt.short_view.crc;
  assign crc_calc  = crc7(crc_data, resp_long ? 7'd120 : 7'd40);
  assign idx_match = resp_long | (resp_nxt.short_view.index == cfg_i.cmd_index);

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      state       <= S_IDLE;
      start_q     <= 1'b0;
      bit_cnt     <= '0;
      sd_cmd_o    <= 1'b1;
      sd_cmd_oe_o <= 1'b0;
      resp_o      <= '0;
      packet_o    <= '0;
      wait_cnt_o  <= '0;
      status_o    <= '0;
    end
    else
    begin
      start_q <= cfg_i.start;
      if (!cfg_i.cmd_en)
      begin
        state           <= S_IDLE;  // held off, line released
        sd_cmd_o        <= 1'b1;
        sd_cmd_oe_o     <= 1'b0;
        status_o.busy   <= 1'b0;
        status_o.finish <= 1'b0;
      end
      else
      begin
        case (state)
          S_IDLE, S_DONE:
          begin
            if (start_rise)
            begin
              packet_o           <= cmd_pkt;
              bit_cnt            <= '0;
              wait_cnt_o         <= '0;
              status_o.finish    <= 1'b0;
              status_o.busy      <= 1'b1;
              status_o.timed_out <= 1'b0;
              status_o.index_ok  <= 1'b0;
              status_o.crc_ok    <= ~cfg_i.setting[2];
              state              <= S_SEND;
            end
          end
          S_SEND:
          begin
            if (tick_i.fall)
            begin
              if (bit_cnt == PKT_W)  // end bit already on the line
              begin
                sd_cmd_o    <= 1'b1;
                sd_cmd_oe_o <= 1'b0;
                bit_cnt     <= '0;
                if (cfg_i.setting[0])
                begin
                  state <= S_WAIT;
                end
                else
                begin
                  state           <= S_DONE;
                  status_o.busy   <= 1'b0;
                  status_o.finish <= 1'b1;
                end
              end
              else
              begin
                sd_cmd_o    <= packet_o[PKT_W-1-bit_cnt];  // msb first
                sd_cmd_oe_o <= 1'b1;
                bit_cnt     <= bit_cnt + 8'd1;
              end
            end
          end
          S_WAIT:
          begin
            if (tick_i.rise)
            begin
              if (!sd_cmd_i)
              begin
                resp_o  <= '0;  // start bit counts as first captured bit
                bit_cnt <= 8'd1;
                state   <= S_CAPT;
              end
              else if (wait_cnt_o == cfg_i.timeout)
              begin
                state              <= S_DONE;
                status_o.busy      <= 1'b0;
                status_o.finish    <= 1'b1;
                status_o.timed_out <= 1'b1;
              end
              else
              begin
                wait_cnt_o <= wait_cnt_o + 32'd1;
              end
            end
          end
          S_CAPT:
          begin
            if (tick_i.rise)
            begin
              resp_o  <= resp_nxt;
              bit_cnt <= bit_cnt + 8'd1;
              if (bit_cnt == resp_len - 8'd1)
              begin
                state             <= S_DONE;
                status_o.busy     <= 1'b0;
                status_o.finish   <= 1'b1;
                status_o.index_ok <= idx_match;
                status_o.crc_ok   <= ~cfg_i.setting[2] | (crc_calc == crc_rx);
              end
            end
          end
          default:
          begin
            state <= S_IDLE;
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- design/sd_readback.sv
`timescale 1ns/100ps
`default_nettype none

module sd_readback (
  input  wire                                 msoc_clk,
  input  wire                                 rstn,
  input  wire sd_host_pkg::host_bus_t         host_i,
  input  wire sd_host_pkg::sd_cfg_t           cfg_i,
  input  wire sd_host_pkg::sd_resp_u          resp_i,
  input  wire [sd_host_pkg::PKT_W-1:0]        packet_i,
  input  wire [sd_host_pkg::DATA_W-1:0]       wait_cnt_i,
  input  wire sd_host_pkg::sd_status_t        status_i,
  input  wire                                 sd_detect_i,
  input  wire [15:0]                          dip_i,
  output logic [sd_host_pkg::DATA_W-1:0]      rdata_o
);
  import sd_host_pkg::*;

  logic [15:0]       dip_q;
  logic              detect_q;
  logic              rd_req;
  logic [DATA_W-1:0] rd_sel;

  assign rd_req = host_i.req & ~host_i.we;

  always_comb
  begin
    case (host_i.addr[6:2])
      RD_RESP0:   rd_sel = resp_i.raw[31:0];
      RD_RESP1:   rd_sel = resp_i.raw[63:32];
      RD_RESP2:   rd_sel = resp_i.raw[95:64];
      RD_RESP3:   rd_sel = resp_i.raw[127:96];
      RD_WAIT:    rd_sel = wait_cnt_i;
      RD_STATUS:  rd_sel = status_i;
      RD_PKT_LO:  rd_sel = packet_i[31:0];
      RD_PKT_HI:  rd_sel = {16'd0, packet_i[47:32]};
      RD_DETECT:  rd_sel = {31'd0, detect_q};
      RD_ARG:     rd_sel = cfg_i.arg;
      RD_CMD:     rd_sel = {26'd0, cfg_i.cmd_index};
      RD_SETTING: rd_sel = {29'd0, cfg_i.setting};
      RD_START:   rd_sel = {31'd0, cfg_i.start};
      RD_RESETS:  rd_sel = {28'd0, cfg_i.card_reset, cfg_i.clk_en, 1'b0, cfg_i.cmd_en};
      RD_TIMEOUT: rd_sel = cfg_i.timeout;
      RD_CLKDIV:  rd_sel = {16'd0, cfg_i.clkdiv};
      RD_DIP:     rd_sel = {16'd0, dip_q};  // boot mode switches
      default:    rd_sel = RD_DEFAULT;
    endcase
  end

  always_ff @(posedge msoc_clk or negedge rstn)
  begin
    if (!rstn)
    begin
      dip_q    <= '0;
      detect_q <= 1'b0;
      rdata_o  <= '0;
    end
    else
    begin
      dip_q    <= dip_i;  // async board inputs
      detect_q <= sd_detect_i;
      if (rd_req)
      begin
        rdata_o <= (host_i.addr[ADDR_W-1:ADDR_W-2] == REGION_STAT) ? rd_sel : '0;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/sd_host_top.sv
`timescale 1ns/100ps
`default_nettype none

module sd_host_top (
  input  wire                             msoc_clk,
  input  wire                             rstn,
  input  wire sd_host_pkg::host_bus_t     host_i,
  output wire [sd_host_pkg::DATA_W-1:0]   rdata_o,
  output wire                             sd_sclk_o,
  output wire                             sd_cmd_o,
  output wire                             sd_cmd_oe_o,
  input  wire                             sd_cmd_i,
  input  wire                             sd_detect_i,
  input  wire [15:0]                      dip_i,
  output wire [7:0]                       led_o,
  output wire                             sd_reset_o
);
  import sd_host_pkg::*;

  sd_cfg_t           cfg;
  sd_tick_t          tick;
  sd_resp_u          resp;
  logic [PKT_W-1:0]  packet;
  logic [DATA_W-1:0] wait_cnt;
  sd_status_t        status;

  sd_ctrl_regs u_regs (
    .msoc_clk   (msoc_clk),
    .rstn       (rstn),
    .host_i     (host_i),
    .cfg_o      (cfg),
    .led_o      (led_o),
    .sd_reset_o (sd_reset_o)
  );

  sd_clk_div u_clk_div (
    .msoc_clk  (msoc_clk),
    .rstn      (rstn),
    .clk_en_i  (cfg.clk_en),
    .clkdiv_i  (cfg.clkdiv),
    .tick_o    (tick),
    .sd_sclk_o (sd_sclk_o)
  );

  sd_cmd_engine u_engine (
    .msoc_clk    (msoc_clk),
    .rstn        (rstn),
    .cfg_i       (cfg),
    .tick_i      (tick),
    .sd_cmd_i    (sd_cmd_i),
    .sd_cmd_o    (sd_cmd_o),
    .sd_cmd_oe_o (sd_cmd_oe_o),
    .resp_o      (resp),
    .packet_o    (packet),
    .wait_cnt_o  (wait_cnt),
    .status_o    (status)
  );

  sd_readback u_readback (
    .msoc_clk    (msoc_clk),
    .rstn        (rstn),
    .host_i      (host_i),
    .cfg_i       (cfg),
    .resp_i      (resp),
    .packet_i    (packet),
    .wait_cnt_i  (wait_cnt),
    .status_i    (status),
    .sd_detect_i (sd_detect_i),
    .dip_i       (dip_i),
    .rdata_o     (rdata_o)
  );

endmodule

`default_nettype wire

//--- verif/sd_card_responder.sv
`timescale 1ns/100ps
`default_nettype none

module sd_card_responder (
  input  wire          sclk_i,
  input  wire          cmd_oe_i,
  input  wire          cmd_i,
  input  wire  [1:0]   mode_i,         // 0 silent, 1 short, 2 long
  input  wire          flip_crc_i,     // corrupt the short response crc
  input  wire  [31:0]  card_status_i,
  input  wire  [119:0] cid_i,
  output logic         cmd_o,
  output logic [47:0]  pkt_o,
  output int           pkt_cnt_o
);

  logic [47:0] shift_q;
  int          nbits;

  // card side crc7, serial lfsr over the low len bits
  function automatic logic [6:0] card_crc7(input logic [119:0] data, input int len);
    logic [6:0] crc;
    logic       inv;
    crc = '0;
    for (int i = len - 1; i >= 0; i--)
    begin
      inv    = data[i] ^ crc[6];
      crc    = {crc[5:0], inv};
      crc[3] = crc[3] ^ inv;
    end
    return crc;
  endfunction

  task automatic send_response(input logic [5:0] idx);
    logic [135:0] frame;
    logic [6:0]   crc;
    int           len;
    frame = '0;
    len   = 0;
    if (mode_i == 2'd1)
    begin
      crc = card_crc7({80'd0, 2'b00, idx, card_status_i}, 40) ^ {6'd0, flip_crc_i};
      frame[135:88] = {2'b00, idx, card_status_i, crc, 1'b1};  // index echoed back
      len = 48;
    end
    else if (mode_i == 2'd2)
    begin
      crc   = card_crc7(cid_i, 120);
      frame = {2'b00, 6'h3F, cid_i, crc, 1'b1};
      len   = 136;
    end
    if (len > 0)
    begin
      repeat (2) @(negedge sclk_i);  // turnaround
      for (int i = 0; i < len; i++)
      begin
        cmd_o <= frame[135-i];
        @(negedge sclk_i);
      end
      cmd_o <= 1'b1;
    end
  endtask

  initial
  begin
    cmd_o     = 1'b1;
    pkt_o     = '0;
    pkt_cnt_o = 0;
    shift_q   = '0;
    nbits     = 0;
    forever
    begin
      @(posedge sclk_i);
      if (cmd_oe_i)
      begin
        shift_q = {shift_q[46:0], cmd_i};
        nbits   = nbits + 1;
        if (nbits == 48)
        begin
          nbits     = 0;
          pkt_o     = shift_q;
          pkt_cnt_o = pkt_cnt_o + 1;
          if (shift_q[47:46] == 2'b01 && shift_q[0])  // well formed host frame
          begin
            send_response(shift_q[45:40]);
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verif/tb_sd_host.sv
`timescale 1ns/100ps
`default_nettype none

module tb_sd_host;
  import sd_host_pkg::*;

  localparam int CLK_PERIOD_NS = 8;
  localparam int CLKDIV_VAL    = 1;
  localparam int TIMEOUT_VAL   = 40;
  localparam int SD_CYCLES     = 2 * (CLKDIV_VAL + 1);  // msoc cycles per sd clock
  localparam int CMD_CYCLES    = (PKT_W + RESP_W + TIMEOUT_VAL + 8) * SD_CYCLES;
  localparam int NUM_CMDS      = 6;
  localparam int WATCHDOG_NS   = NUM_CMDS * (RESP_W + PKT_W + TIMEOUT_VAL) * SD_CYCLES
                                 * CLK_PERIOD_NS + 20000;

  logic              msoc_clk;
  logic              rstn;
  host_bus_t         host;
  logic [DATA_W-1:0] rdata;
  logic              sd_sclk;
  logic              sd_cmd;
  logic              sd_cmd_oe;
  logic              sd_cmd_in;
  logic              sd_detect;
  logic [15:0]       dip;
  logic [7:0]        led;
  logic              sd_reset;
  logic [1:0]        card_mode;
  logic              flip_crc;
  logic [31:0]       card_status;
  logic [119:0]      cid;
  logic [47:0]       card_pkt;
  int                card_pkt_cnt;
  int                seed;

  sd_host_top uut (
    .msoc_clk    (msoc_clk),
    .rstn        (rstn),
    .host_i      (host),
    .rdata_o     (rdata),
    .sd_sclk_o   (sd_sclk),
    .sd_cmd_o    (sd_cmd),
    .sd_cmd_oe_o (sd_cmd_oe),
    .sd_cmd_i    (sd_cmd_in),
    .sd_detect_i (sd_detect),
    .dip_i       (dip),
    .led_o       (led),
    .sd_reset_o  (sd_reset)
  );

  sd_card_responder u_card (
    .sclk_i        (sd_sclk),
    .cmd_oe_i      (sd_cmd_oe),
    .cmd_i         (sd_cmd),
    .mode_i        (card_mode),
    .flip_crc_i    (flip_crc),
    .card_status_i (card_status),
    .cid_i         (cid),
    .cmd_o         (sd_cmd_in),
    .pkt_o         (card_pkt),
    .pkt_cnt_o     (card_pkt_cnt)
  );

  initial msoc_clk = 1'b0;
  always #(CLK_PERIOD_NS / 2) msoc_clk = ~msoc_clk;

  // long division by x^7+x^3+1, msb first over the low len bits
  function automatic logic [6:0] crc7_ref(input logic [119:0] bits, input int len);
    logic [6:0] rem;
    logic       top;
    rem = 7'd0;
    for (int i = len - 1; i >= 0; i--)
    begin
      top = rem[6] ^ bits[i];
      rem = {rem[5:0], 1'b0};
      if (top)
      begin
        rem = rem ^ 7'h09;
      end
    end
    return rem;
  endfunction

  function automatic logic [47:0] packet_ref(input logic [5:0] idx, input logic [31:0] arg);
    return {2'b01, idx, arg, crc7_ref({80'd0, 2'b01, idx, arg}, 40), 1'b1};
  endfunction

  function automatic logic [47:0] short_resp_ref(input logic [5:0] idx, input logic [31:0] st);
    return {2'b00, idx, st, crc7_ref({80'd0, 2'b00, idx, st}, 40), 1'b1};
  endfunction

  function automatic logic [135:0] long_resp_ref(input logic [119:0] body);
    return {2'b00, 6'h3F, body, crc7_ref(body, 120), 1'b1};
  endfunction

  function automatic sd_status_t done_status(input logic tmo, input logic idx_ok,
                                             input logic crc_good);
    sd_status_t s;
    s           = '0;
    s.finish    = 1'b1;
    s.timed_out = tmo;
    s.index_ok  = idx_ok;
    s.crc_ok    = crc_good;
    return s;
  endfunction

  function automatic logic [ADDR_W-1:0] ctrl_addr(input logic [3:0] ofs);
    return {REGION_CTRL, 9'd0, ofs, 2'b00};
  endfunction

  function automatic logic [ADDR_W-1:0] stat_addr(input logic [4:0] ofs);
    return {REGION_STAT, 8'd0, ofs, 2'b00};
  endfunction

  task automatic report_fail(input string line);
    $display("%s", line);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp)
    begin
      report_fail($sformatf("[FAIL] %s expected %08h actual %08h", name, exp, act));
    end
  endtask

  task automatic check_status(input string name, input sd_status_t exp, input sd_status_t act);
    if (act !== exp)
    begin
      report_fail($sformatf("[FAIL] %s expected %08h actual %08h", name, exp, act));
    end
  endtask

  task automatic check_packet(input string name, input logic [47:0] exp, input logic [47:0] act);
    if (act !== exp)
    begin
      report_fail($sformatf("[FAIL] %s expected %012h actual %012h", name, exp, act));
    end
  endtask

  task automatic check_led(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp)
    begin
      report_fail($sformatf("[FAIL] %s expected %02h actual %02h", name, exp, act));
    end
  endtask

  task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    @(posedge msoc_clk);
    host <= '{req: 1'b1, we: 1'b1, addr: addr, wdata: data};
    @(posedge msoc_clk);
    host <= '0;
  endtask

  task automatic bus_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
    @(posedge msoc_clk);
    host <= '{req: 1'b1, we: 1'b0, addr: addr, wdata: '0};
    @(posedge msoc_clk);
    host <= '0;
    @(negedge msoc_clk);  // rdata settled
    data = rdata;
  endtask

  task automatic wait_finish(input string name);
    logic [DATA_W-1:0] word;
    sd_status_t        st;
    int                spent;
    st    = '0;
    spent = 0;
    while (!st.finish)
    begin
      if (spent > CMD_CYCLES)
      begin
        report_fail($sformatf("%s: command never finished within %0d cycles", name, spent));
      end
      bus_read(stat_addr(RD_STATUS), word);
      st    = sd_status_t'(word);
      spent = spent + 2;  // one status poll
    end
  endtask

  task automatic run_cmd(input string name, input logic [5:0] idx, input logic [31:0] arg,
                         input logic [2:0] setting);
    bus_write(ctrl_addr(OFS_ARG), arg);
    bus_write(ctrl_addr(OFS_CMD), {26'd0, idx});
    bus_write(ctrl_addr(OFS_SETTING), {29'd0, setting});
    bus_write(ctrl_addr(OFS_START), 32'd1);
    wait_finish(name);
    bus_write(ctrl_addr(OFS_START), 32'd0);  // rearm for the next edge
  endtask

  initial
  begin
    #(WATCHDOG_NS);
    report_fail($sformatf("watchdog expired after %0d ns, the run hung", WATCHDOG_NS));
  end

  initial
  begin
    logic [31:0]  arg;
    logic [31:0]  word;
    logic [31:0]  word_hi;
    logic [5:0]   idx;
    logic [7:0]   led_val;
    logic [47:0]  pkt_exp;
    logic [47:0]  resp48;
    logic [135:0] resp136;
    logic [127:0] body_raw;
    int           pkt_cnt_before;
    seed        = 32'h2803;
    rstn        = 1'b0;
    host        = '0;
    sd_detect   = 1'b0;
    dip         = '0;
    card_mode   = 2'd0;
    flip_crc    = 1'b0;
    card_status = '0;
    cid         = '0;
    repeat (5) @(posedge msoc_clk);
    rstn <= 1'b1;
    @(negedge msoc_clk);
    check_led("led after reset", 8'h00, led);
    check_word("card reset after reset", 32'd0, {31'd0, sd_reset});
    check_word("sclk after reset", 32'd0, {31'd0, sd_sclk});
    check_word("crc7 of cmd0", 32'h4A, {25'd0, crc7_ref(120'h40_0000_0000, 40)});

    // register write and read back
    word = $random(seed);
    arg  = $random(seed);
    idx     = word[5:0];
    led_val = word[15:8];
    @(posedge msoc_clk);
    dip       <= word[31:16];
    sd_detect <= 1'b1;
    bus_write(ctrl_addr(OFS_ARG), arg);
    bus_write(ctrl_addr(OFS_CMD), {26'd0, idx});
    bus_write(ctrl_addr(OFS_SETTING), 32'd5);
    bus_write(ctrl_addr(OFS_TIMEOUT), TIMEOUT_VAL);
    bus_write(ctrl_addr(OFS_CLKDIV), CLKDIV_VAL);
    bus_write(ctrl_addr(OFS_LED), {24'd0, led_val});
    bus_write(ctrl_addr(OFS_RESETS), 32'hD);  // cmd_en, clk_en and card reset
    bus_read(stat_addr(RD_ARG), word_hi);
    check_word("arg readback", arg, word_hi);
    bus_read(stat_addr(RD_CMD), word_hi);
    check_word("cmd readback", {26'd0, idx}, word_hi);
    bus_read(stat_addr(RD_SETTING), word_hi);
    check_word("setting readback", 32'd5, word_hi);
    bus_read(stat_addr(RD_TIMEOUT), word_hi);
    check_word("timeout readback", TIMEOUT_VAL, word_hi);
    bus_read(stat_addr(RD_CLKDIV), word_hi);
    check_word("clkdiv readback", CLKDIV_VAL, word_hi);
    bus_read(stat_addr(RD_RESETS), word_hi);
    check_word("resets readback", 32'hD, word_hi);
    check_word("card reset output", 32'd1, {31'd0, sd_reset});
    bus_read(stat_addr(5'd13), word_hi);
    check_word("unmapped offset", 32'hDEADBEEF, word_hi);
    bus_read(stat_addr(RD_DIP), word_hi);
    check_word("dip readback", {16'd0, word[31:16]}, word_hi);
    bus_read(stat_addr(RD_DETECT), word_hi);
    check_word("detect readback", 32'd1, word_hi);
    bus_read('0, word_hi);
    check_word("region 0 read", 32'd0, word_hi);
    check_led("led register", led_val, led);

    // command only
    card_mode <= 2'd0;
    arg = $random(seed);
    word = $random(seed);
    idx = word[5:0];
    run_cmd("no response", idx, arg, 3'b000);
    pkt_exp = packet_ref(idx, arg);
    check_packet("no response card packet", pkt_exp, card_pkt);
    bus_read(stat_addr(RD_PKT_LO), word);
    check_word("packet low word", pkt_exp[31:0], word);
    bus_read(stat_addr(RD_PKT_HI), word_hi);
    check_word("packet high word", {16'd0, pkt_exp[47:32]}, word_hi);
    bus_read(stat_addr(RD_STATUS), word);
    check_status("no response status", done_status(1'b0, 1'b0, 1'b1), sd_status_t'(word));

    // short response, good then bad crc
    card_status <= $random(seed);
    card_mode   <= 2'd1;
    arg = $random(seed);
    run_cmd("short response", idx, arg, 3'b101);
    resp48 = short_resp_ref(idx, card_status);
    check_packet("short card packet", packet_ref(idx, arg), card_pkt);
    bus_read(stat_addr(RD_RESP0), word);
    check_word("short resp word 0", resp48[31:0], word);
    bus_read(stat_addr(RD_RESP1), word);
    check_word("short resp word 1", {16'd0, resp48[47:32]}, word);
    bus_read(stat_addr(RD_STATUS), word);
    check_status("short response status", done_status(1'b0, 1'b1, 1'b1), sd_status_t'(word));
    flip_crc <= 1'b1;
    run_cmd("short bad crc", idx, arg, 3'b101);
    bus_read(stat_addr(RD_RESP0), word);
    check_word("bad crc resp word 0", resp48[31:0] ^ 32'h2, word);  // crc lsb sits at bit 1
    bus_read(stat_addr(RD_STATUS), word);
    check_status("bad crc status", done_status(1'b0, 1'b1, 1'b0), sd_status_t'(word));
    flip_crc <= 1'b0;

    // long response with random body
    body_raw = {$random(seed), $random(seed), $random(seed), $random(seed)};
    cid       <= body_raw[119:0];
    card_mode <= 2'd2;
    run_cmd("long response", idx, arg, 3'b111);
    resp136 = long_resp_ref(body_raw[119:0]);
    for (int k = 0; k < 4; k++)
    begin
      bus_read(stat_addr(RD_RESP0 + 5'(k)), word);
      check_word($sformatf("long resp word %0d", k), resp136[32*k +: 32], word);
    end
    bus_read(stat_addr(RD_STATUS), word);
    check_status("long response status", done_status(1'b0, 1'b1, 1'b1), sd_status_t'(word));

    // card stays silent
    card_mode <= 2'd0;
    run_cmd("timeout", idx, arg, 3'b001);
    bus_read(stat_addr(RD_STATUS), word);
    check_status("timeout status", done_status(1'b1, 1'b0, 1'b1), sd_status_t'(word));
    bus_read(stat_addr(RD_WAIT), word);
    check_word("timeout wait count", TIMEOUT_VAL, word);

    // engine held off
    pkt_cnt_before = card_pkt_cnt;
    bus_write(ctrl_addr(OFS_RESETS), 32'h4);  // clock on, engine off
    bus_write(ctrl_addr(OFS_START), 32'd1);
    repeat (60 * SD_CYCLES)
    begin
      @(negedge msoc_clk);
      if (sd_cmd_oe !== 1'b0 || sd_cmd !== 1'b1)
      begin
        report_fail("CMD line was driven although cmd_en is 0");
      end
    end
    check_word("card reset released", 32'd0, {31'd0, sd_reset});
    check_word("packets with cmd_en off", pkt_cnt_before, card_pkt_cnt);
    bus_read(stat_addr(RD_STATUS), word);
    check_word("finish and busy with cmd_en off", 32'd0, {30'd0, word[1:0]});
    bus_write(ctrl_addr(OFS_START), 32'd0);

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
design/sd_host_pkg.sv
design/sd_ctrl_regs.sv
design/sd_clk_div.sv
design/sd_cmd_engine.sv
design/sd_readback.sv
design/sd_host_top.sv
verif/sd_card_responder.sv
verif/tb_sd_host.sv

//--- Makefile
# Verilator build and run of the SD command path testbench
TOP := tb_sd_host
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): compile.f design/*.sv verif/*.sv
	verilator --binary --timing -Wno-fatal -f compile.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f compile.f --top-module sd_host_top

clean:
	rm -rf obj_dir $(LOG)
